/* rtl/rv32Pipe_settings.svh */
// Core-wide constants for the five-stage RV32I pipeline
`ifndef RV32PIPE_SETTINGS_SVH
`define RV32PIPE_SETTINGS_SVH

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Word index widths, 64 words per memory
`define RV_IMEM_AW 6
`define RV_DMEM_AW 6

`endif

/* rtl/rv32PipePkg.sv */
// Shared instruction views, opcode and ALU types, and the ALU function of the core
package rv32PipePkg;

    // One instruction word seen in three encodings
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rView;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iView;
        struct packed {
            logic [6:0] immHi;  // Also {imm[12], imm[10:5]} for branches
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;  // Also {imm[4:1], imm[11]} for branches
            logic [6:0] opcode;
        } sView;
    } instWord;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } aluOpE;

    function automatic logic [31:0] aluCompute(aluOpE op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return {31'd0, $signed(a) < $signed(b)};  // Signed compare
            default: return a + b;
        endcase
    endfunction

endpackage

/* rtl/fetchStage.sv */
// Fetch stage holding the program counter and the IF/ID pipeline register
`timescale 1ns/1ns

`include "rv32Pipe_settings.svh"

module fetchStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectPc,
    input  logic [31:0] imemData,
    output logic [31:0] imemAddr,
    output logic [31:0] ifIdInst,
    output logic [31:0] ifIdPc
);

    logic [31:0] pc;
    logic [31:0] pcNext;

    assign imemAddr = pc;  // Memory answers in the same cycle

    // Redirect wins over a load-use stall
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (stall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifIdInst <= `RV_NOP;
            ifIdPc   <= `RV_RESET_PC;
        end else if (redirect) begin
            ifIdInst <= `RV_NOP;    // Squash the wrong-path fetch
            ifIdPc   <= pc;
        end else if (!stall) begin
            ifIdInst <= imemData;
            ifIdPc   <= pc;
        end
    end

endmodule

/* rtl/decodeStage.sv */
// Decode stage with register file, load-use detection and the ID/EX pipeline register
`timescale 1ns/1ns

module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic [31:0]        ifIdInst,
    input  logic [31:0]        ifIdPc,
    input  logic               redirect,
    input  logic               wbValid,
    input  logic [4:0]         wbRd,
    input  logic [31:0]        wbData,
    output logic               stall,
    output logic [31:0]        idExPc,
    output logic [4:0]         idExRs1,
    output logic [4:0]         idExRs2,
    output logic [4:0]         idExRd,
    output logic [31:0]        idExRdata1,
    output logic [31:0]        idExRdata2,
    output logic [31:0]        idExImm,
    output rv32PipePkg::aluOpE idExAluOp,
    output logic               idExUseImm,
    output logic               idExRegWrite,
    output logic               idExMemRead,
    output logic               idExMemWrite,
    output logic               idExBranch,
    output logic               idExBranchNe
);
    import rv32PipePkg::*;

    instWord     inst;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] imm;
    logic        useRs1;
    logic        useRs2;
    logic        useImm;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        branch;
    aluOpE       aluOp;
    logic [31:0] regFile [32];
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        bubble;

    // funct3 to ALU operation, shared by register and immediate forms
    function automatic aluOpE funct3Op(logic [2:0] f3);
        case (f3)
            3'b010:  return SLT;
            3'b100:  return XOR;
            3'b110:  return OR;
            3'b111:  return AND;
            default: return ADD;
        endcase
    endfunction

    assign inst = ifIdInst;
    assign rs1  = inst.rView.rs1;
    assign rs2  = inst.rView.rs2;
    assign rd   = inst.rView.rd;

    assign immI = {{20{inst.iView.imm[11]}}, inst.iView.imm};
    assign immS = {{20{inst.sView.immHi[6]}}, inst.sView.immHi, inst.sView.immLo};
    assign immB = {{20{inst.sView.immHi[6]}}, inst.sView.immLo[0], inst.sView.immHi[5:0],
                   inst.sView.immLo[4:1], 1'b0};

    always_comb begin
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branch   = 1'b0;
        aluOp    = ADD;
        imm      = immI;
        case (opcodeE'(inst.rView.opcode))
            OP: begin
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                regWrite = 1'b1;
                aluOp    = (inst.rView.funct3 == 3'b000 && inst.rView.funct7[5]) ? SUB
                                                          : funct3Op(inst.rView.funct3);
            end
            OP_IMM: begin
                useRs1   = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                aluOp    = funct3Op(inst.iView.funct3);
            end
            LOAD: begin
                useRs1   = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            STORE: begin
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                useImm   = 1'b1;
                memWrite = 1'b1;
                imm      = immS;
            end
            BRANCH: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                branch = 1'b1;
                imm    = immB;
            end
            default: ;  // Unknown word acts as a NOP
        endcase
        if (rd == 5'd0) begin
            regWrite = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wbValid && wbRd != 5'd0) begin
            regFile[wbRd] <= wbData;
        end
    end

    // Write-first read, x0 reads as zero
    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : (wbValid && wbRd == rs1) ? wbData : regFile[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : (wbValid && wbRd == rs2) ? wbData : regFile[rs2];

    // Load in EX feeding this instruction
    assign stall  = idExMemRead && idExRegWrite &&
                    ((useRs1 && idExRd == rs1) || (useRs2 && idExRd == rs2));
    assign bubble = stall || redirect;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExBranch   <= 1'b0;
            idExBranchNe <= 1'b0;
            idExUseImm   <= 1'b0;
            idExAluOp    <= ADD;
        end else begin
            idExRegWrite <= regWrite && !bubble;
            idExMemRead  <= memRead && !bubble;
            idExMemWrite <= memWrite && !bubble;
            idExBranch   <= branch && !bubble;
            idExBranchNe <= inst.rView.funct3[0] && !bubble;  // BNE has funct3 001
            idExUseImm   <= useImm && !bubble;
            idExAluOp    <= bubble ? ADD : aluOp;
        end
    end

    always_ff @(posedge clk) begin
        idExPc     <= ifIdPc;
        idExRs1    <= useRs1 ? rs1 : 5'd0;
        idExRs2    <= useRs2 ? rs2 : 5'd0;
        idExRd     <= rd;
        idExRdata1 <= rdata1;
        idExRdata2 <= rdata2;
        idExImm    <= imm;
    end

endmodule

/* rtl/executeStage.sv */
// Execute stage with operand forwarding, ALU, branch resolution and the EX/MEM register
`timescale 1ns/1ns

module executeStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic [31:0]        idExPc,
    input  logic [4:0]         idExRs1,
    input  logic [4:0]         idExRs2,
    input  logic [4:0]         idExRd,
    input  logic [31:0]        idExRdata1,
    input  logic [31:0]        idExRdata2,
    input  logic [31:0]        idExImm,
    input  rv32PipePkg::aluOpE idExAluOp,
    input  logic               idExUseImm,
    input  logic               idExRegWrite,
    input  logic               idExMemRead,
    input  logic               idExMemWrite,
    input  logic               idExBranch,
    input  logic               idExBranchNe,
    input  logic               wbValid,
    input  logic [4:0]         wbRd,
    input  logic [31:0]        wbData,
    output logic               redirect,
    output logic [31:0]        redirectPc,
    output logic [31:0]        exMemAlu,
    output logic [31:0]        exMemStoreData,
    output logic [4:0]         exMemRd,
    output logic               exMemRegWrite,
    output logic               exMemRead,
    output logic               exMemWrite
);
    import rv32PipePkg::*;

    logic [31:0] fwdA;
    logic [31:0] fwdB;
    logic [31:0] opB;
    logic [31:0] aluResult;

    // The younger result in EX/MEM wins over MEM/WB
    function automatic logic [31:0] forward(logic [4:0] rs, logic [31:0] regVal);
        if (exMemRegWrite && exMemRd == rs) begin
            return exMemAlu;
        end else if (wbValid && wbRd == rs) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        fwdA = forward(idExRs1, idExRdata1);
        fwdB = forward(idExRs2, idExRdata2);
    end

    assign opB       = idExUseImm ? idExImm : fwdB;
    assign aluResult = aluCompute(idExAluOp, fwdA, opB);

    // BEQ and BNE, taken path squashes the two younger slots
    assign redirect   = idExBranch && ((fwdA == fwdB) != idExBranchNe);
    assign redirectPc = idExPc + idExImm;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMemRegWrite <= 1'b0;
            exMemRead     <= 1'b0;
            exMemWrite    <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemRead     <= idExMemRead;
            exMemWrite    <= idExMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMemAlu       <= aluResult;  // Also the load and store address
        exMemStoreData <= fwdB;
        exMemRd        <= idExRd;
    end

endmodule

/* rtl/memWbStage.sv */
// Memory and writeback stages with the MEM/WB register and the writeback select
`timescale 1ns/1ns

module memWbStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] exMemAlu,
    input  logic [31:0] exMemStoreData,
    input  logic [4:0]  exMemRd,
    input  logic        exMemRegWrite,
    input  logic        exMemRead,
    input  logic        exMemWrite,
    input  logic [31:0] dmemRdData,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWrData,
    output logic        dmemWe,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);

    logic        memWbRead;
    logic [31:0] memWbAlu;
    logic [31:0] memWbLoad;

    // Data memory reads combinationally and writes on the edge
    assign dmemAddr   = exMemAlu;
    assign dmemWrData = exMemStoreData;
    assign dmemWe     = exMemWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid   <= 1'b0;
            memWbRead <= 1'b0;
        end else begin
            wbValid   <= exMemRegWrite;
            memWbRead <= exMemRead;
        end
    end

    always_ff @(posedge clk) begin
        wbRd      <= exMemRd;
        memWbAlu  <= exMemAlu;
        memWbLoad <= dmemRdData;
    end

    assign wbData = memWbRead ? memWbLoad : memWbAlu;  // Load data or ALU result

endmodule

/* rtl/rv32PipeTop.sv */
// Top level of the five-stage RV32I pipeline connecting the four stage blocks
`timescale 1ns/1ns

`include "rv32Pipe_settings.svh"

module rv32PipeTop (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] imemData,
    input  logic [31:0] dmemRdData,
    output logic [31:0] imemAddr,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWrData,
    output logic        dmemWe,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData
);
    import rv32PipePkg::*;

    logic [31:0] fetchAddr;
    logic [31:0] memAddr;
    logic [31:0] ifIdInst;
    logic [31:0] ifIdPc;
    logic        stall;
    logic        redirect;
    logic [31:0] redirectPc;
    logic [31:0] idExPc;
    logic [4:0]  idExRs1;
    logic [4:0]  idExRs2;
    logic [4:0]  idExRd;
    logic [31:0] idExRdata1;
    logic [31:0] idExRdata2;
    logic [31:0] idExImm;
    aluOpE       idExAluOp;
    logic        idExUseImm;
    logic        idExRegWrite;
    logic        idExMemRead;
    logic        idExMemWrite;
    logic        idExBranch;
    logic        idExBranchNe;
    logic [31:0] exMemAlu;
    logic [31:0] exMemStoreData;
    logic [4:0]  exMemRd;
    logic        exMemRegWrite;
    logic        exMemRead;
    logic        exMemWrite;

    // Byte addresses wrapped to the size of each memory
    assign imemAddr = {{(30 - `RV_IMEM_AW){1'b0}}, fetchAddr[`RV_IMEM_AW+1:0]};
    assign dmemAddr = {{(30 - `RV_DMEM_AW){1'b0}}, memAddr[`RV_DMEM_AW+1:0]};

    fetchStage fetch0 (.imemAddr(fetchAddr), .*);

    decodeStage decode0 (.*);

    executeStage execute0 (.*);

    memWbStage memWb0 (.dmemAddr(memAddr), .*);

endmodule

/* tb/rv32Pipe_chk.sv */
// Protocol checker bound into the pipeline top level for reset, fetch and retire rules
`timescale 1ns/1ns

module rv32PipeChk (
    input logic        clk,
    input logic        rstN,
    input logic        wbValid,
    input logic        dmemWe,
    input logic [4:0]  wbRd,
    input logic [31:0] imemAddr
);

    // Nothing retires or stores while reset is held
    quietInReset: assert property (@(posedge clk) !rstN |-> (!wbValid && !dmemWe))
        else $error("Retire or store activity while reset is asserted");

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN) imemAddr[1:0] == 2'b00)
        else $error("Instruction fetch address is not word aligned");

    noX0Retire: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbRd != 5'd0)
        else $error("Register write retired with x0 as destination");

endmodule

bind rv32PipeTop rv32PipeChk chk0 (.*);

/* tb/rv32PipeMonitor.sv */
// Instruction-set model and scoreboard comparing retire and store streams of the pipeline
`timescale 1ns/1ns

`include "rv32Pipe_settings.svh"

module rv32PipeMonitor (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] imemAddr,
    input  logic        wbValid,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    input  logic        dmemWe,
    input  logic [31:0] dmemAddr,
    input  logic [31:0] dmemWrData,
    input  logic [31:0] imemImage [64],
    input  logic [31:0] dmemImage [64],
    output int          errorCount,
    output logic        done
);
    import rv32PipePkg::*;

    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expStore [$];
    logic [31:0] modelRegs [32];
    logic [31:0] haltPc;
    logic        haltSeen = 1'b0;
    logic        ready = 1'b0;
    int          resetErr = 0;
    int          writeErr = 0;
    int          storeErr = 0;
    int          endErr = 0;
    int          cycles = 0;
    int          idle = 0;
    int          writesSeen = 0;
    int          storesSeen = 0;
    int          writesExp = 0;
    int          storesExp = 0;

    initial done = 1'b0;

    task automatic setReg(logic [4:0] rd, logic [31:0] val);
        if (rd != 5'd0) begin
            modelRegs[rd] = val;
            expRd.push_back(rd);
            expData.push_back(val);
        end
    endtask

    // Sequential execution up to the BEQ x0,x0,0 halt
    task automatic runModel();
        logic [31:0] mem [64];
        logic [31:0] pc;
        instWord     w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        aluOpE       op;
        for (int i = 0; i < 32; i++) modelRegs[i] = 32'd0;
        for (int i = 0; i < 64; i++) mem[i] = dmemImage[i];
        pc = `RV_RESET_PC;
        for (int steps = 0; steps < 400; steps++) begin
            w = imemImage[pc[`RV_IMEM_AW+1:2]];
            if (w == 32'h0000_0063) break;
            a    = modelRegs[w.rView.rs1];
            b    = modelRegs[w.rView.rs2];
            immI = {{20{w.iView.imm[11]}}, w.iView.imm};
            immS = {{20{w.sView.immHi[6]}}, w.sView.immHi, w.sView.immLo};
            immB = {{20{w.sView.immHi[6]}}, w.sView.immLo[0], w.sView.immHi[5:0],
                    w.sView.immLo[4:1], 1'b0};
            case (w.rView.funct3)
                3'b010:  op = SLT;
                3'b100:  op = XOR;
                3'b110:  op = OR;
                3'b111:  op = AND;
                default: op = ADD;
            endcase
            pc = pc + 32'd4;
            case (w.rView.opcode)
                7'b0110011: begin
                    if (w.rView.funct3 == 3'b000 && w.rView.funct7[5]) op = SUB;
                    setReg(w.rView.rd, aluCompute(op, a, b));
                end
                7'b0010011: setReg(w.rView.rd, aluCompute(op, a, immI));
                7'b0000011: setReg(w.rView.rd, mem[(a + immI) >> 2 & 32'h3f]);
                7'b0100011: begin
                    mem[(a + immS) >> 2 & 32'h3f] = b;
                    expAddr.push_back(a + immS);
                    expStore.push_back(b);
                end
                7'b1100011: begin
                    if ((a == b) != w.rView.funct3[0]) pc = pc - 32'd4 + immB;
                end
                default: ;
            endcase
        end
        haltPc    = pc;  // Address of the halt loop
        writesExp = expRd.size();
        storesExp = expAddr.size();
    endtask

    always @(negedge clk) begin : sampleEvents
        logic [4:0]  rdExp;
        logic [31:0] valExp;
        if (!rstN) begin
            if (imemAddr !== `RV_RESET_PC) begin
                resetErr++;
                $display("** Error reset: expected imemAddr %h, actual %h",
                         `RV_RESET_PC, imemAddr);
            end
        end else if (!done) begin
            if (!ready) begin
                runModel();
                ready = 1'b1;
            end
            cycles++;
            if (cycles <= 3 && (wbValid || dmemWe)) begin
                resetErr++;
                $display("Retire port active before the first instruction could arrive");
            end
            if (cycles == 4 && !wbValid) begin
                resetErr++;
                $display("First instruction did not retire in its writeback cycle");
            end
            if (cycles == 4) $display("[reset] %s", resetErr == 0 ? "PASS" : "FAIL");
            if (wbValid) begin
                if (expRd.size() == 0) begin
                    endErr++;
                    $display("Unexpected register write to x%0d beyond the model's count", wbRd);
                end else begin
                    rdExp  = expRd.pop_front();
                    valExp = expData.pop_front();
                    writesSeen++;
                    if (rdExp != wbRd || valExp != wbData) begin
                        writeErr++;
                        $display("** Error retire: expected x%0d=%h, actual x%0d=%h",
                                 rdExp, valExp, wbRd, wbData);
                    end
                end
            end
            if (dmemWe) begin
                if (expAddr.size() == 0) begin
                    endErr++;
                    $display("Unexpected store to %h beyond the model's count", dmemAddr);
                end else begin
                    valExp = expAddr.pop_front();
                    storesSeen++;
                    if (valExp != dmemAddr || expStore[0] != dmemWrData) begin
                        storeErr++;
                        $display("** Error store: expected [%h]=%h, actual [%h]=%h",
                                 valExp, expStore[0], dmemAddr, dmemWrData);
                    end
                    void'(expStore.pop_front());
                end
            end
            if (imemAddr == haltPc) haltSeen = 1'b1;
            idle = haltSeen ? idle + 1 : 0;  // Drain time once the halt is fetched
            if (idle == 10) begin
                if (writesSeen != writesExp || storesSeen != storesExp) begin
                    endErr++;
                    $display("Count mismatch at halt: %0d/%0d writes, %0d/%0d stores",
                             writesSeen, writesExp, storesSeen, storesExp);
                end
                $display("[retire] %0d writes %s", writesSeen, writeErr == 0 ? "PASS" : "FAIL");
                $display("[store] %0d stores %s", storesSeen, storeErr == 0 ? "PASS" : "FAIL");
                $display("[completion] %s", endErr == 0 ? "PASS" : "FAIL");
                errorCount = resetErr + writeErr + storeErr + endErr;
                $display("Totals: %0d writes, %0d stores, %0d errors",
                         writesSeen, storesSeen, errorCount);
                done = 1'b1;
            end
        end
    end

endmodule

/* tb/rv32PipeTb.sv */
// Testbench top for the RV32I pipeline with random program, memory models and watchdog
`timescale 1ns/1ns

`include "rv32Pipe_settings.svh"

module rv32PipeTb;

    localparam int TIMEOUT_CYCLES = 48 * 4 + 20;

    logic        clk;
    logic        rstN;
    logic [31:0] imemData;
    logic [31:0] dmemRdData;
    logic [31:0] imemAddr;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWrData;
    logic        dmemWe;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    integer      seed;
    int          errorCount;
    logic        done;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign imemData   = imem[imemAddr[`RV_IMEM_AW+1:2]];
    assign dmemRdData = dmem[dmemAddr[`RV_DMEM_AW+1:2]];

    always @(posedge clk) begin
        if (dmemWe) dmem[dmemAddr[`RV_DMEM_AW+1:2]] = dmemWrData;
    end

    task automatic buildImages();
        logic [31:0] r;
        logic [11:0] off;
        logic [12:0] br;
        logic [2:0]  f3;
        int          k;
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            dmem[i] = r;
            imem[i] = {i[11:0], 20'h00013};  // ADDI x0,x0,index
        end
        for (int i = 0; i < 48; i++) begin
            r = $random(seed);
            case (r[14:13])
                2'd0:    f3 = 3'b000;
                2'd1:    f3 = 3'b111;
                2'd2:    f3 = 3'b110;
                default: f3 = (r[29] && r[2]) ? 3'b010 : 3'b100;
            endcase
            off = {4'd0, r[20:15], 2'b00};
            if (i < 7) begin
                imem[i] = {r[26:15], 5'd0, 3'b000, 5'(i + 1), 7'b0010011};  // Seed x1..x7
            end else begin
                case (r[3:0] % 10)
                    0, 1, 2: imem[i] = {(f3 == 3'b000 && r[29]) ? 7'h20 : 7'h00, 2'b00,
                                        r[12:10], 2'b00, r[9:7], f3, 2'b00, r[6:4], 7'b0110011};
                    3, 4, 5: imem[i] = {r[26:15], 2'b00, r[9:7], f3, 2'b00, r[6:4],
                                        7'b0010011};
                    6:       imem[i] = {off, 5'd0, 3'b010, 2'b00, r[6:4], 7'b0000011};
                    7:       imem[i] = {off[11:5], 2'b00, r[12:10], 5'd0, 3'b010, off[4:0],
                                        7'b0100011};
                    default: begin
                        k  = 2 + r[28:27];
                        if (i + k > 48) k = 48 - i;  // Never past the halt
                        br = 13'(k * 4);
                        imem[i] = {br[12], br[10:5], 2'b00, r[12:10], 2'b00, r[9:7],
                                   2'b00, r[29], br[4:1], br[11], 7'b1100011};
                    end
                endcase
            end
        end
        imem[48] = 32'h0000_0063;  // BEQ x0,x0,0
    endtask

    rv32PipeTop dut0 (
        .clk(clk),
        .rstN(rstN),
        .imemData(imemData),
        .dmemRdData(dmemRdData),
        .imemAddr(imemAddr),
        .dmemAddr(dmemAddr),
        .dmemWrData(dmemWrData),
        .dmemWe(dmemWe),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData)
    );

    rv32PipeMonitor monitor0 (
        .clk(clk),
        .rstN(rstN),
        .imemAddr(imemAddr),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData),
        .dmemWe(dmemWe),
        .dmemAddr(dmemAddr),
        .dmemWrData(dmemWrData),
        .imemImage(imem),
        .dmemImage(dmem),
        .errorCount(errorCount),
        .done(done)
    );

    initial begin
        seed = 7141;
        rstN <= 1'b0;
        buildImages();
        repeat (4) @(negedge clk);
        rstN <= 1'b1;  // Released after the monitor has sampled this edge
        wait (done);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (4 + TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the program did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

/* rv32Pipe.f */
+incdir+rtl
rtl/rv32PipePkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/rv32PipeTop.sv
tb/rv32Pipe_chk.sv
tb/rv32PipeMonitor.sv
tb/rv32PipeTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rv32PipeTb
FILELIST  ?= rv32Pipe.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
